// ==== source/bbc_mem_consts.svh ====
//================================================
// sizes and limits shared by the memory glue
// ROM_WORDS must stay a multiple of one 16 KB bank
// RAM_BYTES is smaller than the 18-bit RAM window,
// addresses past it are not backed
//================================================

`ifndef BBC_MEM_CONSTS_SVH
`define BBC_MEM_CONSTS_SVH

// external bus of the machine core
`define BUS_ADDR_W      19
`define RAM_SEL_BIT     18
`define SLOT_ADDR_W     14

// packed ROM store, one image per bank
`define ROM_BANKS       14
`define ROM_WORDS       (`ROM_BANKS * 8192)

// main, shadow and sideways RAM together
`define RAM_BYTES       212992

// mouse to analog joystick
`define MOUSE_STEP_MAX  10
`define AXIS_MIN        (-128)
`define AXIS_MAX        127

`endif

// ==== source/bbc_mem_pkg.sv ====
//================================================
// struct types for the memory glue and mouse path
// field order follows the core and loader wiring,
// do not reorder without changing the sources
//================================================

`include "bbc_mem_consts.svh"

package bbc_mem_pkg;

	// bus request from the machine core
	typedef struct packed {
		logic [`BUS_ADDR_W-1:0] addr;
		logic                   we_n;
		logic [7:0]             data;
	} bus_req_t;

	// ROM loader, one 16-bit word per wr pulse
	// addr is a byte address
	typedef struct packed {
		logic        wr;
		logic [17:0] addr;
		logic [15:0] data;
	} rom_load_t;

	// decode result
	typedef struct packed {
		logic [3:0] rom_bank;
		logic       is_ram;
		logic       slot_valid;
	} map_dec_t;

	// raw mouse packet, bit 24 toggles per packet
	typedef struct packed {
		logic       stb;
		logic [6:0] dy;
		logic       rsvd_16;
		logic [6:0] dx;
		logic [2:0] rsvd_8_6;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] rsvd_3_2;
		logic [1:0] btn;
	} mouse_pkt_t;

	// emulated analog joystick
	typedef struct packed {
		logic [7:0] x;
		logic [7:0] y;
		logic       fire;
	} joy_axis_t;

endpackage

// ==== source/mem_map_decode.sv ====
//================================================
// sideways slot to ROM bank mapping
// purely combinational, output follows addr
// m128 is expected stable while the core runs
//================================================

`timescale 1ns/1ps

`include "bbc_mem_consts.svh"

module mem_map_decode (
	input  logic [`BUS_ADDR_W-1:0] addr,
	input  logic                   m128,
	output bbc_mem_pkg::map_dec_t  dec
);

	// 16 KB slot index, bits 17..14
	logic [3:0] slot;

	assign slot = addr[`SLOT_ADDR_W+3:`SLOT_ADDR_W];

	// RAM select passes straight through
	assign dec.is_ram = addr[`RAM_SEL_BIT];

	always_comb begin
		// empty slot unless matched below
		dec.rom_bank   = 4'd0;
		dec.slot_valid = 1'b1;
		case ({m128, slot})
			// B model, banks 0..3
			5'b0_0100: dec.rom_bank = 4'd0;
			// filing system
			5'b0_1000: dec.rom_bank = 4'd1;
			5'b0_1110: dec.rom_bank = 4'd2;
			// language slot
			5'b0_1111: dec.rom_bank = 4'd3;

			// Master model, banks 4..13
			5'b1_0010: dec.rom_bank = 4'd4;
			5'b1_0011: dec.rom_bank = 4'd5;
			// MOS lives in slot 4 here, not bank 0
			5'b1_0100: dec.rom_bank = 4'd6;
			5'b1_1001: dec.rom_bank = 4'd7;
			5'b1_1010: dec.rom_bank = 4'd8;
			5'b1_1011: dec.rom_bank = 4'd9;
			5'b1_1100: dec.rom_bank = 4'd10;
			5'b1_1101: dec.rom_bank = 4'd11;
			5'b1_1110: dec.rom_bank = 4'd12;
			5'b1_1111: dec.rom_bank = 4'd13;

			default: begin
				dec.rom_bank   = 4'd0;
				dec.slot_valid = 1'b0;
			end
		endcase
	end

endmodule

// ==== source/mem_store.sv ====
//================================================
// ROM word store and RAM byte store
// loader writes only while hold is high
// RAM write fires once per falling edge of we_n
// both reads are registered, one cycle latency
//================================================

`timescale 1ns/1ps

`include "bbc_mem_consts.svh"

module mem_store (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  bbc_mem_pkg::bus_req_t  bus,
	input  bbc_mem_pkg::map_dec_t  dec,
	input  logic                   hold,
	input  bbc_mem_pkg::rom_load_t rom_load,
	output logic [15:0]            rom_word,
	output logic [7:0]             ram_byte
);

	localparam int ROM_AW = $clog2(`ROM_WORDS);

	logic [15:0] rom [`ROM_WORDS];
	logic [7:0]  ram [`RAM_BYTES];

	logic [ROM_AW-1:0]       rom_raddr;
	logic [`RAM_SEL_BIT-1:0] ram_addr;
	// last sampled write strobe
	logic                    we_prev;
	logic                    ram_we;

	// bank on top, word offset inside the 16 KB slot below
	assign rom_raddr = {dec.rom_bank, bus.addr[`SLOT_ADDR_W-1:1]};
	assign ram_addr  = bus.addr[`RAM_SEL_BIT-1:0];
	assign ram_we    = dec.is_ram & we_prev & ~bus.we_n;

	//================================================
	// ROM
	//================================================
	always_ff @(posedge clk_sys) begin
		// low loader byte is the even byte, high half of the word
		if (rom_load.wr && hold) begin
			rom[rom_load.addr[17:1]] <= {rom_load.data[7:0], rom_load.data[15:8]};
		end
		rom_word <= rom[rom_raddr];
	end

	//================================================
	// RAM
	//================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			// strobe idles high
			we_prev <= 1'b1;
		end else begin
			we_prev <= bus.we_n;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_addr] <= bus.data;
		end
		ram_byte <= ram[ram_addr];
	end

endmodule

// ==== source/read_return.sv ====
//================================================
// read data return to the core
// decode is delayed to line up with the memories
// empty ROM slots read as zero
//================================================

`timescale 1ns/1ps

module read_return (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  bus_lsb,
	input  bbc_mem_pkg::map_dec_t dec,
	input  logic [15:0]           rom_word,
	input  logic [7:0]            ram_byte,
	output logic [7:0]            rdata
);

	bbc_mem_pkg::map_dec_t dec_q;
	logic                  lsb_q;

	// same stage as rom_word / ram_byte
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			dec_q <= '0;
			lsb_q <= 1'b0;
		end else begin
			dec_q <= dec;
			lsb_q <= bus_lsb;
		end
	end

	always_comb begin
		if (dec_q.is_ram) begin
			rdata = ram_byte;
		end else if (dec_q.slot_valid) begin
			// even byte sits in the high half
			rdata = lsb_q ? rom_word[7:0] : rom_word[15:8];
		end else begin
			rdata = 8'h00;
		end
	end

endmodule

// ==== source/mouse_axis_emu.sv ====
//================================================
// analog joystick emulated from mouse movement
// one update per toggle of the packet strobe
// any joystick button, hold or mouse_off gives
// control back to the real joystick
//================================================

`timescale 1ns/1ps

`include "bbc_mem_consts.svh"

module mouse_axis_emu (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    hold,
	input  bbc_mem_pkg::mouse_pkt_t mouse,
	input  logic                    mouse_off,
	input  logic [7:0]              joy_x,
	input  logic [7:0]              joy_y,
	input  logic [15:0]             joy_btn,
	output bbc_mem_pkg::joy_axis_t  axis
);

	localparam logic signed [8:0] STEP_MAX = 9'(`MOUSE_STEP_MAX);
	localparam logic signed [8:0] POS_MIN  = 9'(`AXIS_MIN);
	localparam logic signed [8:0] POS_MAX  = 9'(`AXIS_MAX);

	logic              mouse_mode;
	logic              stb_prev;
	logic signed [8:0] mx, my;
	logic signed [8:0] mdx, mdy;
	logic signed [8:0] mdx_c, mdy_c;
	logic signed [8:0] nmx, nmy;
	logic        [7:0] src_x, src_y;

	// 9-bit signed steps from sign bit and magnitude field
	assign mdx = {mouse.x_sign, mouse.x_sign, mouse.dx};
	assign mdy = {mouse.y_sign, mouse.y_sign, mouse.dy};

	// clamp each step
	assign mdx_c = (mdx > STEP_MAX) ? STEP_MAX : (mdx < -STEP_MAX) ? -STEP_MAX : mdx;
	assign mdy_c = (mdy > STEP_MAX) ? STEP_MAX : (mdy < -STEP_MAX) ? -STEP_MAX : mdy;

	// mouse y grows downward, joystick y upward
	assign nmx = mx + mdx_c;
	assign nmy = my - mdy_c;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			stb_prev   <= 1'b0;
			mouse_mode <= 1'b0;
			mx         <= '0;
			my         <= '0;
		end else begin
			stb_prev <= mouse.stb;
			// real joystick wins
			if ((|joy_btn) || hold || mouse_off) begin
				mouse_mode <= 1'b0;
				mx         <= '0;
				my         <= '0;
			end else if (stb_prev != mouse.stb) begin
				mouse_mode <= 1'b1;
				mx <= (nmx < POS_MIN) ? POS_MIN : (nmx > POS_MAX) ? POS_MAX : nmx;
				my <= (nmy < POS_MIN) ? POS_MIN : (nmy > POS_MAX) ? POS_MAX : nmy;
			end
		end
	end

	//================================================
	// output mapping
	//================================================
	assign src_x = mouse_mode ? mx[7:0] : joy_x;
	assign src_y = mouse_mode ? my[7:0] : joy_y;

	// signed to offset binary, then inverted sense
	assign axis.x    = 8'hFF - {~src_x[7], src_x[6:0]};
	assign axis.y    = 8'hFF - {~src_y[7], src_y[6:0]};
	assign axis.fire = mouse_mode ? (|mouse.btn) : joy_btn[4];

endmodule

// ==== source/bbc_glue_top.sv ====
//================================================
// memory bus glue and mouse joystick top level
// model is only sampled while hold is high,
// changing model_master at run time has no effect
// rdata is valid one cycle after the address
//================================================

`timescale 1ns/1ps

module bbc_glue_top (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  logic                    hold,
	input  logic                    model_master,
	input  bbc_mem_pkg::bus_req_t   bus,
	input  bbc_mem_pkg::rom_load_t  rom_load,
	input  bbc_mem_pkg::mouse_pkt_t mouse,
	input  logic                    mouse_off,
	input  logic [7:0]              joy_x,
	input  logic [7:0]              joy_y,
	input  logic [15:0]             joy_btn,
	output logic [7:0]              rdata,
	output bbc_mem_pkg::joy_axis_t  axis
);

	// latched model, 1 = Master
	logic                  m128;
	bbc_mem_pkg::map_dec_t dec;
	logic [15:0]           rom_word;
	logic [7:0]            ram_byte;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			m128 <= 1'b0;
		end else if (hold) begin
			m128 <= model_master;
		end
	end

	//================================================
	// memory path
	//================================================
	mem_map_decode u_decode (
		.addr (bus.addr),
		.m128 (m128),
		.dec  (dec)
	);

	mem_store u_store (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.bus      (bus),
		.dec      (dec),
		.hold     (hold),
		.rom_load (rom_load),
		.rom_word (rom_word),
		.ram_byte (ram_byte)
	);

	read_return u_return (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.bus_lsb  (bus.addr[0]),
		.dec      (dec),
		.rom_word (rom_word),
		.ram_byte (ram_byte),
		.rdata    (rdata)
	);

	// mouse as joystick
	mouse_axis_emu u_mouse (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.hold      (hold),
		.mouse     (mouse),
		.mouse_off (mouse_off),
		.joy_x     (joy_x),
		.joy_y     (joy_y),
		.joy_btn   (joy_btn),
		.axis      (axis)
	);

endmodule

// ==== sim/bbc_glue_properties.sv ====
//================================================
// concurrent checks bound into the top level
// the axis check assumes joy_x and joy_y at zero
//================================================

`timescale 1ns/1ps

module bbc_glue_properties (
	input logic                   clk_sys,
	input logic                   rst_n,
	input logic                   hold,
	input logic [7:0]             joy_x,
	input logic [7:0]             joy_y,
	input bbc_mem_pkg::map_dec_t  dec,
	input logic [7:0]             rdata,
	input bbc_mem_pkg::joy_axis_t axis
);

	// empty slot reads as zero one cycle later
	a_empty_slot_zero: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(!dec.is_ram && !dec.slot_valid) |=> (rdata == 8'h00))
		else $error("rdata not zero after an empty slot read");

	// hold drops mouse mode so a centred joystick reads 7F
	a_hold_axis_centre: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(hold && joy_x == 8'h00 && joy_y == 8'h00) |=>
		(joy_x != 8'h00 || joy_y != 8'h00 || (axis.x == 8'h7F && axis.y == 8'h7F)))
		else $error("axis not centred on the cycle after hold");

endmodule

bind bbc_glue_top bbc_glue_properties u_props (
	.clk_sys (clk_sys),
	.rst_n   (rst_n),
	.hold    (hold),
	.joy_x   (joy_x),
	.joy_y   (joy_y),
	.dec     (dec),
	.rdata   (rdata),
	.axis    (axis)
);

// ==== sim/tb_bbc_glue.sv ====
//================================================
// testbench for the memory glue and mouse joystick
// inputs change on the falling edge only
// ROM banks are filled completely before reading
// read data is expected one cycle after the address
//================================================

`timescale 1ns/1ps

`include "bbc_mem_consts.svh"

module tb_bbc_glue;

	localparam int WAIT_LIMIT = 16;

	logic                    clk_sys;
	logic                    rst_n;
	logic                    hold;
	logic                    model_master;
	bbc_mem_pkg::bus_req_t   bus;
	bbc_mem_pkg::rom_load_t  rom_load;
	bbc_mem_pkg::mouse_pkt_t mouse;
	logic                    mouse_off;
	logic [7:0]              joy_x;
	logic [7:0]              joy_y;
	logic [15:0]             joy_btn;
	logic [7:0]              rdata;
	bbc_mem_pkg::joy_axis_t  axis;

	// reference memories holding loader words as written
	logic [15:0] rom_ref [`ROM_BANKS][8192];
	logic [7:0]  ram_ref [int];
	logic [31:0] rng;
	int          errors;
	int          checks;
	// read waiting for its data
	logic        pend_valid;
	logic [7:0]  pend_exp;
	logic [18:0] pend_addr;
	// reference mouse position
	int          pos_x;
	int          pos_y;

	// slot lists where the list index gives the bank (plus 4 on Master)
	int b_slots [4]  = '{4, 8, 14, 15};
	int m_slots [10] = '{2, 3, 4, 9, 10, 11, 12, 13, 14, 15};
	int e_slots [4]  = '{0, 1, 5, 9};

	bbc_glue_top DUT (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.hold         (hold),
		.model_master (model_master),
		.bus          (bus),
		.rom_load     (rom_load),
		.mouse        (mouse),
		.mouse_off    (mouse_off),
		.joy_x        (joy_x),
		.joy_y        (joy_y),
		.joy_btn      (joy_btn),
		.rdata        (rdata),
		.axis         (axis)
	);

	initial clk_sys = 1'b0;
	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [18:0] make_addr(input int slot, input logic [13:0] ofs);
		return {1'b0, 4'(slot), ofs};
	endfunction

	// even byte is the loader's low byte
	function automatic logic [7:0] rom_byte(input int bank, input logic [13:0] ofs);
		logic [15:0] w;
		w = rom_ref[bank][ofs[13:1]];
		return ofs[0] ? w[15:8] : w[7:0];
	endfunction

	// 255 minus offset binary, i.e. 255 - (p + 128)
	function automatic logic [7:0] axis_of(input int p);
		return 8'(127 - p);
	endfunction

	function automatic int sat_pos(input int p);
		return (p < `AXIS_MIN) ? `AXIS_MIN : (p > `AXIS_MAX) ? `AXIS_MAX : p;
	endfunction

	function automatic int clamp_step(input int s);
		return (s > `MOUSE_STEP_MAX) ? `MOUSE_STEP_MAX :
			(s < -`MOUSE_STEP_MAX) ? -`MOUSE_STEP_MAX : s;
	endfunction

	//================================================
	// read pipe and checks
	//================================================
	task automatic retire_read();
		if (pend_valid) begin
			checks++;
			assert (rdata == pend_exp) else begin
				$display("** Error at %0t: read %05h got %02h, expected %02h",
					$time, pend_addr, rdata, pend_exp);
				errors++;
			end
		end
	endtask

	// check the previous read, then present the next address
	task automatic issue_read(input logic [18:0] addr, input logic [7:0] exp);
		@(negedge clk_sys);
		retire_read();
		bus.addr   = addr;
		bus.we_n   = 1'b1;
		pend_addr  = addr;
		pend_exp   = exp;
		pend_valid = 1'b1;
	endtask

	task automatic drain_read();
		@(negedge clk_sys);
		retire_read();
		pend_valid = 1'b0;
	endtask

	task automatic load_bank(input int bank);
		logic [15:0] w;
		for (int i = 0; i < 8192; i++) begin
			@(negedge clk_sys);
			rng = xorshift(rng);
			w = rng[15:0];
			rom_ref[bank][i] = w;
			rom_load.wr   = 1'b1;
			rom_load.addr = 18'(bank * 16384 + i * 2);
			rom_load.data = w;
		end
		@(negedge clk_sys);
		rom_load.wr = 1'b0;
	endtask

	// poll the axis until it matches, bounded by WAIT_LIMIT
	task automatic wait_axis(input logic [7:0] ex, input logic [7:0] ey, input logic ef);
		int n;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
		end while ((axis.x != ex || axis.y != ey || axis.fire != ef) && n < WAIT_LIMIT);
		checks++;
		assert (axis.x == ex && axis.y == ey && axis.fire == ef) else begin
			$display("** Error at %0t: axis %02h %02h %b, expected %02h %02h %b",
				$time, axis.x, axis.y, axis.fire, ex, ey, ef);
			errors++;
		end
	endtask

	// one packet with the reference updated by the clamp and saturation rules
	task automatic send_mouse(input int dx, input int dy, input logic [1:0] btn);
		pos_x = sat_pos(pos_x + clamp_step(dx));
		pos_y = sat_pos(pos_y - clamp_step(dy));
		@(negedge clk_sys);
		mouse.stb    = ~mouse.stb;
		mouse.dx     = 7'(dx);
		mouse.x_sign = (dx < 0);
		mouse.dy     = 7'(dy);
		mouse.y_sign = (dy < 0);
		mouse.btn    = btn;
		wait_axis(axis_of(pos_x), axis_of(pos_y), |btn);
	endtask

	//================================================
	// stimulus
	//================================================
	initial begin
		logic [17:0] a;
		logic [7:0]  d;
		logic [17:0] addrs [16];
		logic [13:0] ofs;

		rng        = 32'h3745_edff;
		errors     = 0;
		checks     = 0;
		pend_valid = 1'b0;
		pend_exp   = '0;
		pend_addr  = '0;
		pos_x      = 0;
		pos_y      = 0;
		rst_n        = 1'b0;
		hold         = 1'b1;
		model_master = 1'b0;
		bus          = '0;
		bus.we_n     = 1'b1;
		rom_load     = '0;
		mouse        = '0;
		mouse_off    = 1'b0;
		joy_x        = 8'h00;
		joy_y        = 8'h00;
		joy_btn      = 16'h0000;
		repeat (3) @(negedge clk_sys);
		rst_n = 1'b1;

		// back-to-back even and odd reads over all four B banks
		for (int b = 0; b < 4; b++) begin
			load_bank(b);
		end
		@(negedge clk_sys);
		hold = 1'b0;
		for (int k = 0; k < 4; k++) begin
			for (int j = 0; j < 16; j++) begin
				rng = xorshift(rng);
				ofs = {rng[13:1], j[0]};
				issue_read(make_addr(b_slots[k], ofs), rom_byte(k, ofs));
			end
		end
		// empty B slots
		for (int k = 0; k < 4; k++) begin
			rng = xorshift(rng);
			issue_read(make_addr(e_slots[k], rng[13:0]), 8'h00);
		end
		drain_read();

		// slot 4 maps to bank 6 on the Master model
		@(negedge clk_sys);
		hold         = 1'b1;
		model_master = 1'b1;
		for (int b = 4; b < `ROM_BANKS; b++) begin
			load_bank(b);
		end
		@(negedge clk_sys);
		hold = 1'b0;
		for (int k = 0; k < 10; k++) begin
			for (int j = 0; j < 6; j++) begin
				rng = xorshift(rng);
				ofs = {rng[13:1], j[0]};
				issue_read(make_addr(m_slots[k], ofs), rom_byte(k + 4, ofs));
			end
		end
		drain_read();

		// single-cycle RAM strobes then read back
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			a = 18'(rng % `RAM_BYTES);
			rng = xorshift(rng);
			d = rng[7:0];
			@(negedge clk_sys);
			bus.addr = {1'b1, a};
			bus.data = d;
			bus.we_n = 1'b0;
			ram_ref[int'(a)] = d;
			addrs[i] = a;
			@(negedge clk_sys);
			bus.we_n = 1'b1;
		end
		for (int i = 0; i < 16; i++) begin
			issue_read({1'b1, addrs[i]}, ram_ref[int'(addrs[i])]);
		end
		drain_read();

		// later data must not land while the strobe stays low
		rng = xorshift(rng);
		a = 18'(rng % `RAM_BYTES);
		d = rng[31:24];
		@(negedge clk_sys);
		bus.addr = {1'b1, a};
		bus.data = d;
		bus.we_n = 1'b0;
		for (int i = 0; i < 4; i++) begin
			@(negedge clk_sys);
			bus.data = bus.data + 8'd1;
		end
		issue_read({1'b1, a}, d);
		drain_read();

		//================================================
		// mouse to joystick
		//================================================
		// big steps clamp while x climbs to max and y falls to min
		for (int i = 0; i < 15; i++) begin
			send_mouse(30, 30, 2'b01);
		end
		for (int i = 0; i < 30; i++) begin
			send_mouse(-30, -30, 2'b00);
		end
		for (int i = 0; i < 16; i++) begin
			rng = xorshift(rng);
			send_mouse(int'(rng[2:0]) - 3, int'(rng[5:3]) - 3, rng[7:6]);
		end
		// joystick button takes control back
		rng = xorshift(rng);
		@(negedge clk_sys);
		joy_x   = rng[7:0];
		joy_y   = rng[15:8];
		joy_btn = 16'h0010;
		pos_x   = 0;
		pos_y   = 0;
		wait_axis(axis_of(int'($signed(joy_x))), axis_of(int'($signed(joy_y))), 1'b1);
		// back to mouse, then mouse_off
		@(negedge clk_sys);
		joy_btn = 16'h0000;
		send_mouse(7, -4, 2'b10);
		@(negedge clk_sys);
		mouse_off = 1'b1;
		pos_x     = 0;
		pos_y     = 0;
		wait_axis(axis_of(int'($signed(joy_x))), axis_of(int'($signed(joy_y))), 1'b0);
		// hold hands control back while the mouse is in use
		@(negedge clk_sys);
		mouse_off = 1'b0;
		joy_x     = 8'h00;
		joy_y     = 8'h00;
		send_mouse(5, 5, 2'b00);
		@(negedge clk_sys);
		hold  = 1'b1;
		pos_x = 0;
		pos_y = 0;
		wait_axis(axis_of(0), axis_of(0), 1'b0);
		@(negedge clk_sys);
		hold = 1'b0;

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+source
source/bbc_mem_pkg.sv
source/mem_map_decode.sv
source/mem_store.sv
source/read_return.sv
source/mouse_axis_emu.sv
source/bbc_glue_top.sv
sim/bbc_glue_properties.sv
sim/tb_bbc_glue.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the glue testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_bbc_glue --Mdir "$build_dir" -f filelist.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/Vtb_bbc_glue" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$log_file"; then
	exit 1
fi
exit 0
